// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_isa_pkg::alu_op_t alu_op,
    input  logic [2:0]          funct3,
    input  rv_isa_pkg::word_t   a,
    input  rv_isa_pkg::word_t   b,
    output rv_isa_pkg::word_t   result,
    output logic                branch_taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    // one set of comparators serves SLT/SLTU and the branches
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (alu_op)
            rv_isa_pkg::ADD:  result = a + b;
            rv_isa_pkg::SUB:  result = a - b;
            rv_isa_pkg::SLL:  result = a << shamt;
            rv_isa_pkg::SLT:  result = {31'b0, lt_s};
            rv_isa_pkg::SLTU: result = {31'b0, lt_u};
            rv_isa_pkg::XOR:  result = a ^ b;
            rv_isa_pkg::SRL:  result = a >> shamt;
            rv_isa_pkg::SRA:  result = rv_isa_pkg::word_t'($signed(a) >>> shamt);
            rv_isa_pkg::OR:   result = a | b;
            default:          result = a & b;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  branch_taken = eq;
            rv_isa_pkg::F3_BNE:  branch_taken = !eq;
            rv_isa_pkg::F3_BLT:  branch_taken = lt_s;
            rv_isa_pkg::F3_BGE:  branch_taken = !lt_s;
            rv_isa_pkg::F3_BLTU: branch_taken = lt_u;
            rv_isa_pkg::F3_BGEU: branch_taken = !lt_u;
            default:             branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_cfg_pkg.sv
`default_nettype none

package cpu_cfg_pkg;

    // word-indexed memories
    localparam int IMEM_AW    = 8;
    localparam int DMEM_AW    = 8;
    localparam int IMEM_WORDS = 2 ** IMEM_AW;
    localparam int DMEM_WORDS = 2 ** DMEM_AW;

    typedef logic [IMEM_AW-1:0] imem_addr_t;
    typedef logic [DMEM_AW-1:0] dmem_addr_t;

    // output port flow control
    typedef logic [1:0] credit_t;
    localparam credit_t OUT_CREDITS = 2'd2;

    typedef enum logic [2:0] {
        FETCH, FETCH_WAIT, DECODE, EXECUTE, MEM_WAIT, OUT_WAIT, WRITE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic                    clk,
    input  logic                    rstn,
    output cpu_cfg_pkg::imem_addr_t imem_addr,
    input  rv_isa_pkg::inst_t       imem_inst,
    output cpu_cfg_pkg::dmem_addr_t dmem_addr,
    output logic                    dmem_we,
    output rv_isa_pkg::word_t       dmem_wdata,
    input  rv_isa_pkg::word_t       dmem_rdata,
    output logic                    out_valid,
    output rv_isa_pkg::word_t       out_data,
    input  logic                    credit_return,
    output logic [6:0]              pc_led
);

    cpu_cfg_pkg::ctrl_state_t state;
    cpu_cfg_pkg::credit_t     credits;
    rv_isa_pkg::word_t        pc;
    rv_isa_pkg::word_t        pc_plus4;
    rv_isa_pkg::word_t        pc_target;
    rv_isa_pkg::inst_t        inst_q;

    // decoder outputs
    logic d_is_alu, d_is_load, d_is_store, d_is_branch;
    logic d_is_jal, d_is_jalr, d_is_lui, d_is_out, d_use_imm;
    rv_isa_pkg::reg_addr_t d_rs1, d_rs2, d_rd;
    rv_isa_pkg::word_t     d_imm;
    rv_isa_pkg::alu_op_t   d_alu_op;
    logic [2:0]            d_funct3;
    rv_isa_pkg::word_t     rs1_val, rs2_val;

    // fields held from DECODE
    logic is_alu_q, is_load_q, is_store_q, is_branch_q;
    logic is_jal_q, is_jalr_q, is_lui_q, is_out_q;
    rv_isa_pkg::reg_addr_t rd_q;
    rv_isa_pkg::word_t     imm_q, a_q, b_q, rs2_q;
    rv_isa_pkg::alu_op_t   alu_op_q;
    logic [2:0]            funct3_q;

    rv_isa_pkg::word_t alu_result;
    logic              branch_taken;

    // write-back and next pc, set up in EXECUTE
    rv_isa_pkg::word_t next_pc_q, wb_data_q;
    logic              wb_en_q;
    logic              rf_we;

    reg_file u_reg_file (
        .clk    (clk),
        .rstn   (rstn),
        .we     (rf_we),
        .waddr  (rd_q),
        .wdata  (wb_data_q),
        .raddr1 (d_rs1),
        .raddr2 (d_rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    inst_decoder u_dec (
        .inst      (inst_q),
        .is_alu    (d_is_alu),
        .is_load   (d_is_load),
        .is_store  (d_is_store),
        .is_branch (d_is_branch),
        .is_jal    (d_is_jal),
        .is_jalr   (d_is_jalr),
        .is_lui    (d_is_lui),
        .is_out    (d_is_out),
        .use_imm   (d_use_imm),
        .rs1       (d_rs1),
        .rs2       (d_rs2),
        .rd        (d_rd),
        .imm       (d_imm),
        .alu_op    (d_alu_op),
        .funct3    (d_funct3)
    );

    alu u_alu (
        .alu_op       (alu_op_q),
        .funct3       (funct3_q),
        .a            (a_q),
        .b            (b_q),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    assign pc_plus4   = pc + 32'd4;
    assign pc_target  = pc + imm_q;
    assign imem_addr  = pc[cpu_cfg_pkg::IMEM_AW+1:2];
    assign pc_led     = pc[6:0];

    // memory access is issued in EXECUTE, read data lands in MEM_WAIT
    assign dmem_addr  = alu_result[cpu_cfg_pkg::DMEM_AW+1:2];
    assign dmem_we    = (state == cpu_cfg_pkg::EXECUTE) && is_store_q;
    assign dmem_wdata = rs2_q;

    assign out_valid  = (state == cpu_cfg_pkg::OUT_WAIT) && (credits != '0);
    assign out_data   = a_q;
    assign rf_we      = (state == cpu_cfg_pkg::WRITE) && wb_en_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= cpu_cfg_pkg::FETCH;
            pc    <= '0;
        end else begin
            case (state)
                cpu_cfg_pkg::FETCH:      state <= cpu_cfg_pkg::FETCH_WAIT;
                cpu_cfg_pkg::FETCH_WAIT: state <= cpu_cfg_pkg::DECODE;
                cpu_cfg_pkg::DECODE:     state <= cpu_cfg_pkg::EXECUTE;
                cpu_cfg_pkg::EXECUTE: begin
                    if (is_load_q || is_store_q) begin
                        state <= cpu_cfg_pkg::MEM_WAIT;
                    end else if (is_out_q) begin
                        state <= cpu_cfg_pkg::OUT_WAIT;
                    end else begin
                        state <= cpu_cfg_pkg::WRITE;
                    end
                end
                cpu_cfg_pkg::MEM_WAIT:   state <= cpu_cfg_pkg::WRITE;
                cpu_cfg_pkg::OUT_WAIT: begin
                    // hold until a credit is free
                    if (out_valid) begin
                        state <= cpu_cfg_pkg::WRITE;
                    end
                end
                cpu_cfg_pkg::WRITE: begin
                    pc    <= {next_pc_q[31:2], 2'b00};
                    state <= cpu_cfg_pkg::FETCH;
                end
                default:                 state <= cpu_cfg_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_cfg_pkg::FETCH_WAIT) begin
            inst_q <= imem_inst;
        end
        if (state == cpu_cfg_pkg::DECODE) begin
            is_alu_q    <= d_is_alu;
            is_load_q   <= d_is_load;
            is_store_q  <= d_is_store;
            is_branch_q <= d_is_branch;
            is_jal_q    <= d_is_jal;
            is_jalr_q   <= d_is_jalr;
            is_lui_q    <= d_is_lui;
            is_out_q    <= d_is_out;
            rd_q        <= d_rd;
            imm_q       <= d_imm;
            alu_op_q    <= d_alu_op;
            funct3_q    <= d_funct3;
            a_q         <= rs1_val;
            b_q         <= d_use_imm ? d_imm : rs2_val;
            rs2_q       <= rs2_val;
        end
        if (state == cpu_cfg_pkg::EXECUTE) begin
            wb_en_q   <= is_alu_q | is_load_q | is_lui_q | is_jal_q | is_jalr_q;
            wb_data_q <= alu_result;
            next_pc_q <= pc_plus4;
            if (is_lui_q) begin
                wb_data_q <= imm_q;
            end
            // link value for both jumps
            if (is_jal_q || is_jalr_q) begin
                wb_data_q <= pc_plus4;
            end
            if (is_jal_q || (is_branch_q && branch_taken)) begin
                next_pc_q <= pc_target;
            end
            if (is_jalr_q) begin
                next_pc_q <= alu_result;
            end
        end
        if (state == cpu_cfg_pkg::MEM_WAIT && is_load_q) begin
            wb_data_q <= dmem_rdata;
        end
    end

    // a send and a return in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits <= cpu_cfg_pkg::OUT_CREDITS;
        end else if (out_valid && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (credit_return && !out_valid) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    prog_we,
    input  cpu_cfg_pkg::imem_addr_t prog_addr,
    input  rv_isa_pkg::inst_t       prog_data,
    output logic                    out_valid,
    output rv_isa_pkg::word_t       out_data,
    input  logic                    credit_return,
    output logic [6:0]              pc_led
);

    cpu_cfg_pkg::imem_addr_t imem_addr;
    rv_isa_pkg::inst_t       imem_inst;
    cpu_cfg_pkg::dmem_addr_t dmem_addr;
    logic                    dmem_we;
    rv_isa_pkg::word_t       dmem_wdata;
    rv_isa_pkg::word_t       dmem_rdata;

    cpu_core u_core (
        .clk           (clk),
        .rstn          (rstn),
        .imem_addr     (imem_addr),
        .imem_inst     (imem_inst),
        .dmem_addr     (dmem_addr),
        .dmem_we       (dmem_we),
        .dmem_wdata    (dmem_wdata),
        .dmem_rdata    (dmem_rdata),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return),
        .pc_led        (pc_led)
    );

    inst_mem u_imem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .addr      (imem_addr),
        .inst      (imem_inst)
    );

    data_mem u_dmem (
        .clk   (clk),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: logic/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                    clk,
    input  logic                    we,
    input  cpu_cfg_pkg::dmem_addr_t addr,
    input  rv_isa_pkg::word_t       wdata,
    output rv_isa_pkg::word_t       rdata
);

    rv_isa_pkg::word_t mem [cpu_cfg_pkg::DMEM_WORDS];

    // word writes only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  rv_isa_pkg::inst_t     inst,
    output logic                  is_alu,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  is_lui,
    output logic                  is_out,
    output logic                  use_imm,
    output rv_isa_pkg::reg_addr_t rs1,
    output rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::reg_addr_t rd,
    output rv_isa_pkg::word_t     imm,
    output rv_isa_pkg::alu_op_t   alu_op,
    output logic [2:0]            funct3
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    // funct7 bit 5 selects SUB and SRA
    logic                alt;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign alt    = inst[30];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        is_alu    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_lui    = 1'b0;
        is_out    = 1'b0;
        use_imm   = 1'b0;
        imm       = imm_i;
        case (opcode)
            rv_isa_pkg::OP_ALU: is_alu = 1'b1;
            rv_isa_pkg::OP_ALUI: begin
                is_alu  = 1'b1;
                use_imm = 1'b1;
            end
            rv_isa_pkg::OP_LUI: begin
                is_lui = 1'b1;
                imm    = imm_u;
            end
            rv_isa_pkg::OP_LOAD: begin
                is_load = 1'b1;
                use_imm = 1'b1;
            end
            rv_isa_pkg::OP_STORE: begin
                is_store = 1'b1;
                use_imm  = 1'b1;
                imm      = imm_s;
            end
            rv_isa_pkg::OP_BRANCH: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            rv_isa_pkg::OP_JAL: begin
                is_jal = 1'b1;
                imm    = imm_j;
            end
            rv_isa_pkg::OP_JALR: begin
                is_jalr = 1'b1;
                use_imm = 1'b1;
            end
            rv_isa_pkg::OP_OUT: is_out = 1'b1;
            // unknown opcode runs as a no-op
            default: ;
        endcase
    end

    // address arithmetic for loads, stores and jalr uses ADD
    always_comb begin
        alu_op = rv_isa_pkg::ADD;
        if (is_alu) begin
            case (funct3)
                rv_isa_pkg::F3_ADD_SUB: begin
                    if (alt && opcode == rv_isa_pkg::OP_ALU) begin
                        alu_op = rv_isa_pkg::SUB;
                    end
                end
                rv_isa_pkg::F3_SLL:  alu_op = rv_isa_pkg::SLL;
                rv_isa_pkg::F3_SLT:  alu_op = rv_isa_pkg::SLT;
                rv_isa_pkg::F3_SLTU: alu_op = rv_isa_pkg::SLTU;
                rv_isa_pkg::F3_XOR:  alu_op = rv_isa_pkg::XOR;
                rv_isa_pkg::F3_SRL_SRA: begin
                    alu_op = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
                end
                rv_isa_pkg::F3_OR:   alu_op = rv_isa_pkg::OR;
                default:             alu_op = rv_isa_pkg::AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem (
    input  logic                    clk,
    input  logic                    prog_we,
    input  cpu_cfg_pkg::imem_addr_t prog_addr,
    input  rv_isa_pkg::inst_t       prog_data,
    input  cpu_cfg_pkg::imem_addr_t addr,
    output rv_isa_pkg::inst_t       inst
);

    rv_isa_pkg::inst_t mem [cpu_cfg_pkg::IMEM_WORDS];

    // loaded while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        inst <= mem[addr];
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  we,
    input  rv_isa_pkg::reg_addr_t waddr,
    input  rv_isa_pkg::word_t     wdata,
    input  rv_isa_pkg::reg_addr_t raddr1,
    input  rv_isa_pkg::reg_addr_t raddr2,
    output rv_isa_pkg::word_t     rdata1,
    output rv_isa_pkg::word_t     rdata2
);

    rv_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    // custom-0, sends rs1 to the output port
    localparam opcode_t OP_OUT    = 7'b0001011;

    // arithmetic funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

endpackage

`default_nettype wire

// File: sim.f
logic/rv_isa_pkg.sv
logic/cpu_cfg_pkg.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/alu.sv
logic/cpu_core.sv
logic/inst_mem.sv
logic/data_mem.sv
logic/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// File: verification/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
    input wire logic                     clk,
    input wire logic                     rstn,
    input wire logic                     out_valid,
    input wire cpu_cfg_pkg::ctrl_state_t state,
    input wire cpu_cfg_pkg::credit_t     credits
);

    // outstanding words are OUT_CREDITS minus the credits still held
    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credits <= cpu_cfg_pkg::OUT_CREDITS)
        else $error("output credit counter above its initial count");

    a_single_pulse: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles in a row");

    a_quiet_after_reset: assert property (@(posedge clk)
        !rstn |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_legal_state: assert property (@(posedge clk) disable iff (!rstn)
        state inside {cpu_cfg_pkg::FETCH, cpu_cfg_pkg::FETCH_WAIT, cpu_cfg_pkg::DECODE,
                      cpu_cfg_pkg::EXECUTE, cpu_cfg_pkg::MEM_WAIT, cpu_cfg_pkg::OUT_WAIT,
                      cpu_cfg_pkg::WRITE})
        else $error("control state outside its enum");

endmodule

bind cpu_core cpu_props u_props (
    .clk       (clk),
    .rstn      (rstn),
    .out_valid (out_valid),
    .state     (state),
    .credits   (credits)
);

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int NUM_TESTS = 8;

    logic                    clk;
    logic                    rstn;
    logic                    prog_we;
    cpu_cfg_pkg::imem_addr_t prog_addr;
    rv_isa_pkg::inst_t       prog_data;
    logic                    out_valid;
    rv_isa_pkg::word_t       out_data;
    logic                    credit_return;
    logic [6:0]              pc_led;

    // test table
    string             names [NUM_TESTS];
    rv_isa_pkg::word_t prog [NUM_TESTS][24];
    rv_isa_pkg::word_t expv [NUM_TESTS][8];
    int                plen [NUM_TESTS];
    int                n_exp [NUM_TESTS];
    bit                rmode [NUM_TESTS];
    bit                warm [NUM_TESTS];
    rv_isa_pkg::word_t warm_prog [3];

    // return delays for the random credit mode
    int   credit_delay [64];

    int   cyc = 0;
    int   rst_cycles = 0;
    int   cur = 0;
    bit   checking = 0;
    bit   rand_credit = 0;
    int   recv_count, test_errors, error_count = 0;
    int   passed = 0;
    int   failed = 0;
    int   outstanding, last_due, due;
    logic ret;
    int   pending [$];
    longint limit_ns = 0;

    cpu_top UUT (
        .clk           (clk),
        .rstn          (rstn),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return),
        .pc_led        (pc_led)
    );

    always #2 clk = ~clk;

    // instruction encoders
    function automatic rv_isa_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv_isa_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_isa_pkg::OP_ALU};
    endfunction

    function automatic rv_isa_pkg::word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    function automatic rv_isa_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::OP_JAL};
    endfunction

    function automatic rv_isa_pkg::word_t enc_out(int rs1);
        return {12'b0, rs1[4:0], 3'b0, 5'b0, rv_isa_pkg::OP_OUT};
    endfunction

    function automatic rv_isa_pkg::word_t addi(int rd, int rs1, int imm);
        return enc_i(imm, rs1, 0, rd, rv_isa_pkg::OP_ALUI);
    endfunction

    task automatic add_inst(input int t, input rv_isa_pkg::word_t w);
        prog[t][plen[t]] = w;
        plen[t]++;
    endtask

    task automatic add_expected(input int t, input rv_isa_pkg::word_t w);
        expv[t][n_exp[t]] = w;
        n_exp[t]++;
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::word_t exp_w,
                              input rv_isa_pkg::word_t act_w);
        if (exp_w !== act_w) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp_w, act_w);
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            plen[t] = 0;
            n_exp[t] = 0;
            rmode[t] = 0;
            warm[t] = 0;
        end
        names[0] = "alu";
        add_inst(0, addi(1, 0, -5));
        add_inst(0, addi(2, 0, 3));
        add_inst(0, enc_r(32, 2, 1, 0, 3));
        add_inst(0, enc_out(3));
        add_inst(0, enc_i('h401, 1, 5, 4, rv_isa_pkg::OP_ALUI));
        add_inst(0, enc_out(4));
        add_inst(0, enc_r(0, 2, 1, 2, 5));
        add_inst(0, enc_out(5));
        add_inst(0, enc_r(0, 2, 1, 3, 5));
        add_inst(0, enc_out(5));
        add_inst(0, enc_i(4, 2, 1, 6, rv_isa_pkg::OP_ALUI));
        add_inst(0, enc_out(6));
        add_inst(0, enc_r(0, 2, 1, 4, 7));
        add_inst(0, enc_out(7));
        add_expected(0, 32'hffff_fff8);
        add_expected(0, 32'hffff_fffd);
        add_expected(0, 32'h1);
        add_expected(0, 32'h0);
        add_expected(0, 32'h30);
        add_expected(0, 32'hffff_fff8);
        names[1] = "memory";
        add_inst(1, addi(1, 0, 'h11));
        add_inst(1, addi(2, 0, 'h22));
        add_inst(1, addi(3, 0, 'h33));
        add_inst(1, enc_s(0, 1, 0));
        add_inst(1, enc_s(8, 2, 0));
        add_inst(1, enc_s(4, 3, 0));
        add_inst(1, enc_i(4, 0, 2, 4, rv_isa_pkg::OP_LOAD));
        add_inst(1, enc_out(4));
        add_inst(1, enc_i(0, 0, 2, 5, rv_isa_pkg::OP_LOAD));
        add_inst(1, enc_out(5));
        add_inst(1, enc_i(8, 0, 2, 6, rv_isa_pkg::OP_LOAD));
        add_inst(1, enc_out(6));
        add_expected(1, 32'h33);
        add_expected(1, 32'h11);
        add_expected(1, 32'h22);
        names[2] = "branch_loop";
        add_inst(2, addi(1, 0, 0));
        add_inst(2, addi(2, 0, 3));
        add_inst(2, addi(1, 1, 1));
        add_inst(2, enc_out(1));
        add_inst(2, enc_b(-8, 2, 1, 1));
        for (int k = 1; k <= 3; k++) begin
            add_expected(2, k);
        end
        // taken branches skip out x1, fall-through ones send x2
        names[3] = "branch_eq_ne_lt";
        names[4] = "branch_ge_ltu_geu";
        for (int t = 3; t <= 4; t++) begin
            add_inst(t, addi(1, 0, -1));
            add_inst(t, addi(2, 0, 1));
        end
        add_inst(3, enc_b(8, 2, 2, 0));
        add_inst(3, enc_out(1));
        add_inst(3, enc_b(8, 2, 1, 0));
        add_inst(3, enc_out(2));
        add_inst(3, enc_b(8, 2, 1, 1));
        add_inst(3, enc_out(1));
        add_inst(3, enc_b(8, 2, 2, 1));
        add_inst(3, enc_out(2));
        add_inst(3, enc_b(8, 2, 1, 4));
        add_inst(3, enc_out(1));
        add_inst(3, enc_b(8, 1, 2, 4));
        add_inst(3, enc_out(2));
        add_inst(4, enc_b(8, 1, 2, 5));
        add_inst(4, enc_out(1));
        add_inst(4, enc_b(8, 2, 1, 5));
        add_inst(4, enc_out(2));
        add_inst(4, enc_b(8, 1, 2, 6));
        add_inst(4, enc_out(1));
        add_inst(4, enc_b(8, 2, 1, 6));
        add_inst(4, enc_out(2));
        add_inst(4, enc_b(8, 2, 1, 7));
        add_inst(4, enc_out(1));
        add_inst(4, enc_b(8, 1, 2, 7));
        add_inst(4, enc_out(2));
        for (int k = 0; k < 3; k++) begin
            add_expected(3, 32'h1);
            add_expected(4, 32'h1);
        end
        names[5] = "jump_lui";
        add_inst(5, enc_j(8, 5));
        add_inst(5, enc_out(6));
        add_inst(5, enc_out(5));
        add_inst(5, addi(6, 0, 26));
        // target 27 lands on 24
        add_inst(5, enc_i(1, 6, 0, 7, rv_isa_pkg::OP_JALR));
        add_inst(5, enc_out(0));
        add_inst(5, enc_out(7));
        add_inst(5, {20'habcde, 5'd8, rv_isa_pkg::OP_LUI});
        add_inst(5, enc_out(8));
        add_inst(5, addi(0, 0, 5));
        add_inst(5, enc_out(0));
        add_expected(5, 32'h4);
        add_expected(5, 32'h14);
        add_expected(5, 32'habcd_e000);
        add_expected(5, 32'h0);
        names[6] = "backpressure";
        rmode[6] = 1;
        for (int k = 1; k <= 8; k++) begin
            add_inst(6, addi(k, 0, k));
        end
        // back-to-back sends outrun the returned credits
        for (int k = 1; k <= 8; k++) begin
            add_inst(6, enc_out(k));
            add_expected(6, k);
        end
        names[7] = "reset_reload";
        warm[7] = 1;
        add_inst(7, addi(1, 0, 'h77));
        add_inst(7, enc_out(1));
        add_expected(7, 32'h77);
        warm_prog[0] = addi(1, 0, 'h5a);
        warm_prog[1] = enc_out(1);
        warm_prog[2] = enc_j(-4, 0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            add_inst(t, enc_j(0, 0));
            limit_ns += 4 * (plen[t] * 6 * 50 + 24 + 2 + 40 + (warm[t] ? 70 : 0));
        end
    endtask

    // program load happens with the core held in reset
    task automatic reset_and_load(input int t, input bit use_warm);
        int n;
        n = use_warm ? 3 : plen[t];
        @(posedge clk);
        #1;
        rstn = 1'b0;
        for (int i = 0; i < 8 || i < n; i++) begin
            prog_we = (i < n);
            prog_addr = i[7:0];
            prog_data = use_warm ? warm_prog[i % 3] : prog[t][i % 24];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        rstn = 1'b1;
    endtask

    task automatic run_test(input int t);
        int waited;
        cur = t;
        rand_credit = rmode[t];
        test_errors = 0;
        checking = 0;
        if (warm[t]) begin
            reset_and_load(t, 1'b1);
            repeat (60) @(posedge clk);
        end
        reset_and_load(t, 1'b0);
        recv_count = 0;
        checking = 1;
        waited = 0;
        while (recv_count < n_exp[t] && waited < plen[t] * 300) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (recv_count < n_exp[t]) begin
            error_count++;
            test_errors++;
            $display("test %s: only %0d of %0d outputs arrived", names[t], recv_count,
                     n_exp[t]);
        end
        // quiet period catches extra words
        repeat (40) @(posedge clk);
        #1;
        checking = 0;
        // the program parks on its closing self-jump
        check_word({names[t], " pc_led"}, rv_isa_pkg::word_t'(((plen[t] - 1) * 4) % 128),
                   rv_isa_pkg::word_t'(pc_led));
        if (test_errors == 0) begin
            passed++;
            $display("test %s: passed", names[t]);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", names[t], test_errors);
        end
    endtask

    // output monitor and credit model
    always @(posedge clk) begin
        cyc++;
        if (!rstn) begin
            if (rst_cycles > 0 && out_valid) begin
                error_count++;
                test_errors++;
                $display("test %s: out_valid pulsed during reset", names[cur]);
            end
            rst_cycles++;
            pending.delete();
            outstanding = 0;
            last_due = 0;
            #1 credit_return = 1'b0;
        end else begin
            rst_cycles = 0;
            if (credit_return) begin
                outstanding--;
            end
            if (out_valid) begin
                outstanding++;
                if (outstanding > cpu_cfg_pkg::OUT_CREDITS) begin
                    error_count++;
                    test_errors++;
                    $display("test %s: word sent with no credit left", names[cur]);
                end
                due = cyc + (rand_credit ? credit_delay[recv_count % 64] : 0);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pending.push_back(due);
                if (checking && recv_count < n_exp[cur]) begin
                    check_word(names[cur], expv[cur][recv_count], out_data);
                end else if (checking) begin
                    error_count++;
                    test_errors++;
                    $display("test %s: unexpected extra output %h", names[cur], out_data);
                end
                recv_count++;
            end
            ret = (pending.size() > 0) && (pending[0] <= cyc);
            if (ret) begin
                void'(pending.pop_front());
            end
            #1 credit_return = ret;
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired before the tests completed");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        credit_return = 1'b0;
        void'($urandom(32'h72ea_9589));
        for (int k = 0; k < 64; k++) begin
            credit_delay[k] = int'($urandom % 32);
        end
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS, passed, failed,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
